/* dcache.f */
verilog/dcache_pkg.sv
verilog/l1_array_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

/* verification/dcache_tb.sv */
// dcache testbench: random CPU traffic, an L2 responder and a reference cache model
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int NUM_REQ = 400;
    localparam int W       = dcache_pkg::WORD_W;

    logic                   clk;
    logic                   reset;
    logic                   cpu_req;
    logic                   cpu_we;
    logic                   cpu_ack;
    dcache_pkg::word_addr_t cpu_addr;
    dcache_pkg::word_t      cpu_wdata;
    dcache_pkg::word_t      cpu_rdata;
    logic                   l2_req;
    logic                   l2_we;
    logic                   l2_ack;
    dcache_pkg::line_addr_t l2_addr;
    dcache_pkg::line_t      l2_wdata;
    dcache_pkg::line_t      l2_rdata;
    integer                 seed = 32'h40aa_b914;

    dcache_pkg::word_t      flat_mem [dcache_pkg::word_addr_t];  // latest value per word
    dcache_pkg::line_t      l2_mem [dcache_pkg::line_addr_t];
    dcache_pkg::tag_t       m_tag [2][dcache_pkg::NUM_SETS];
    logic                   m_valid [2][dcache_pkg::NUM_SETS];
    logic                   m_dirty [2][dcache_pkg::NUM_SETS];
    logic                   m_lru [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::LINE_ADDR_W:0] l2_log [$];  // {we, addr} of each L2 transaction
    dcache_pkg::line_t      l2_log_data [$];

    dcache_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wdata  (l2_wdata),
        .l2_ack    (l2_ack),
        .l2_rdata  (l2_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // untouched L2 contents, spread over the whole word address
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::word_addr_t a);
        return {a[15:0], ~a[29:14]} ^ 32'h9e37_79b9;
    endfunction

    function automatic dcache_pkg::word_t model_word(input dcache_pkg::word_addr_t a);
        return flat_mem.exists(a) ? flat_mem[a] : init_word(a);
    endfunction

    function automatic dcache_pkg::word_t l2_word(input dcache_pkg::word_addr_t a);
        dcache_pkg::line_addr_t la;
        la = a[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
        if (!l2_mem.exists(la))
            return init_word(a);
        return l2_mem[la][a[dcache_pkg::OFFSET_W-1:0]*W +: W];
    endfunction

    function automatic dcache_pkg::line_t gather_line(input dcache_pkg::line_addr_t la,
                                                      input logic from_l2);
        dcache_pkg::line_t      line;
        dcache_pkg::word_addr_t a;
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            a = {la, dcache_pkg::offset_t'(i)};
            line[i*W +: W] = from_l2 ? l2_word(a) : model_word(a);
        end
        return line;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else abort_run(what);
    endtask

    // one four-phase CPU transaction, entered and left on a rising edge
    task automatic run_request(input logic we, input dcache_pkg::word_addr_t addr,
                               input dcache_pkg::word_t wdata,
                               output dcache_pkg::word_t rdata, output int cycles);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!cpu_ack);
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_req <= 1'b0;
        do @(negedge clk); while (cpu_ack);
        @(posedge clk);
    endtask

    initial begin : l2_responder
        int delay;
        l2_ack   = 1'b0;
        l2_rdata = '0;
        forever begin
            @(negedge clk);
            if (l2_req && !l2_ack) begin
                delay = $unsigned($random(seed)) % 6;  // busy L2 just answers late
                l2_log.push_back({l2_we, l2_addr});
                l2_log_data.push_back(l2_wdata);
                repeat (delay) @(negedge clk);
                @(posedge clk);
                if (l2_we)
                    l2_mem[l2_addr] = l2_wdata;
                else
                    l2_rdata <= gather_line(l2_addr, 1'b1);
                l2_ack <= 1'b1;
                do @(negedge clk); while (l2_req);
                @(posedge clk);
                l2_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_REQ * 40 * 4);
        abort_run("timeout: the cache stopped completing requests");
    end

    initial begin : stimulus
        logic [31:0]            rnd;
        logic                   we;
        logic                   hit0;
        logic                   hit1;
        logic                   way;
        logic                   dirty_victim;
        logic                   in_dirty;
        dcache_pkg::tag_t       tag;
        dcache_pkg::index_t     idx;
        dcache_pkg::word_addr_t addr;
        dcache_pkg::word_t      wdata;
        dcache_pkg::word_t      rdata;
        dcache_pkg::line_addr_t victim_line;
        dcache_pkg::line_t      exp_wb;
        int                     cycles;
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < NUM_REQ; n++) begin
            rnd   = $random(seed);
            we    = rnd[0];
            tag   = 20'h0a5c3 ^ (20'h13579 * (rnd[15:8] % 3));  // 3 tags fight for 4 sets
            idx   = 8'h3c * rnd[17:16];
            addr  = {tag, idx, rnd[21:20]};
            wdata = $random(seed);
            // model lookup and replacement choice
            hit0 = m_valid[0][idx] && (m_tag[0][idx] == tag);
            hit1 = m_valid[1][idx] && (m_tag[1][idx] == tag);
            if (hit0 || hit1)
                way = hit1;
            else if (!m_valid[0][idx])
                way = 1'b0;
            else if (!m_valid[1][idx])
                way = 1'b1;
            else
                way = m_lru[idx];
            dirty_victim = !(hit0 || hit1) && m_valid[way][idx] && m_dirty[way][idx];
            victim_line  = {m_tag[way][idx], idx};
            exp_wb       = gather_line(victim_line, 1'b0);
            l2_log.delete();
            l2_log_data.delete();
            run_request(we, addr, wdata, rdata, cycles);
            if (hit0 || hit1) begin
                check_true(l2_log.size() == 0, "a predicted hit went out to L2");
                check_value("hit latency", cycles, we ? 4 : 3);
            end else if (dirty_victim) begin
                check_true(l2_log.size() == 2, "dirty miss did not give a writeback and a refill");
                check_value("l2_addr of writeback", l2_log[0], {1'b1, victim_line});
                check_value("l2_wdata", l2_log_data[0], exp_wb);
                check_value("l2_addr of refill", l2_log[1], {1'b0, addr[29:2]});
            end else begin
                check_true(l2_log.size() == 1, "clean miss did not give exactly one L2 read");
                check_value("l2_addr of refill", l2_log[0], {1'b0, addr[29:2]});
            end
            if (!we)
                check_value("cpu_rdata", rdata, model_word(addr));
            if (!(hit0 || hit1)) begin
                m_tag[way][idx]   = tag;
                m_valid[way][idx] = 1'b1;
                m_dirty[way][idx] = 1'b0;
            end
            m_lru[idx] = ~way;
            if (we) begin
                flat_mem[addr]    = wdata;
                m_dirty[way][idx] = 1'b1;
            end
        end
        // words outside dirty lines must already sit in L2
        foreach (flat_mem[wa]) begin
            tag      = wa[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
            idx      = wa[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
            in_dirty = (m_valid[0][idx] && m_dirty[0][idx] && m_tag[0][idx] == tag)
                       || (m_valid[1][idx] && m_dirty[1][idx] && m_tag[1][idx] == tag);
            if (!in_dirty)
                check_value("l2 memory word", l2_word(wa), flat_mem[wa]);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dcache_assert.sv */
// handshake checks on the cache controller's CPU and L2 ports
`timescale 1ns/1ps
`default_nettype none

module dcache_assert (
    input logic                    clk,
    input logic                    reset,
    input logic                    cpu_req,
    input logic                    cpu_ack,
    input logic                    l2_req,
    input logic                    l2_we,
    input dcache_pkg::line_addr_t  l2_addr,
    input dcache_pkg::line_t       l2_wdata,
    input logic                    l2_ack,
    input dcache_pkg::ctrl_state_t state
);

    // ack only answers a live request
    cpu_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cpu_ack) |-> cpu_req)
        else $error("cpu_ack rose while cpu_req was low");

    // request and its fields held until l2 answers
    l2_req_held: assert property (@(posedge clk) disable iff (reset)
        (l2_req && !l2_ack) |=> l2_req && $stable(l2_we) && $stable(l2_addr)
                                && $stable(l2_wdata))
        else $error("l2 request changed before l2_ack");

    l2_req_not_idle: assert property (@(posedge clk) disable iff (reset)
        (state == dcache_pkg::IDLE) |-> !l2_req)
        else $error("l2_req high while the controller is idle");

endmodule

bind dcache_ctrl dcache_assert assert0 (
    .clk      (clk),
    .reset    (reset),
    .cpu_req  (cpu_req),
    .cpu_ack  (cpu_ack),
    .l2_req   (l2_req),
    .l2_we    (l2_we),
    .l2_addr  (l2_addr),
    .l2_wdata (l2_wdata),
    .l2_ack   (l2_ack),
    .state    (state)
);

`default_nettype wire

/* verilog/dcache_top.sv */
// two-way write-back L1 data cache, controller plus tag and data arrays
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                   clk,
    input  logic                   reset,
    // cpu port
    input  logic                   cpu_req,
    input  logic                   cpu_we,
    input  dcache_pkg::word_addr_t cpu_addr,
    input  dcache_pkg::word_t      cpu_wdata,
    output logic                   cpu_ack,
    output dcache_pkg::word_t      cpu_rdata,
    // l2 port, whole lines
    output logic                   l2_req,
    output logic                   l2_we,
    output dcache_pkg::line_addr_t l2_addr,
    output dcache_pkg::line_t      l2_wdata,
    input  logic                   l2_ack,
    input  dcache_pkg::line_t      l2_rdata
);

    l1_array_if arr_if ();

    dcache_ctrl ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wdata  (l2_wdata),
        .l2_ack    (l2_ack),
        .l2_rdata  (l2_rdata),
        .arr       (arr_if.ctrl)
    );

    dcache_tag_array tags0 (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_if.tags)
    );

    dcache_data_array data0 (
        .clk (clk),
        .arr (arr_if.data)
    );

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
// cache controller FSM: lookup, write hit, writeback, refill and both req/ack ports
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    // cpu side
    input  logic                   cpu_req,
    input  logic                   cpu_we,
    input  dcache_pkg::word_addr_t cpu_addr,
    input  dcache_pkg::word_t      cpu_wdata,
    output logic                   cpu_ack,
    output dcache_pkg::word_t      cpu_rdata,
    // l2 side
    output logic                   l2_req,
    output logic                   l2_we,
    output dcache_pkg::line_addr_t l2_addr,
    output dcache_pkg::line_t      l2_wdata,
    input  logic                   l2_ack,
    input  dcache_pkg::line_t      l2_rdata,
    // arrays
    l1_array_if.ctrl               arr
);

    dcache_pkg::ctrl_state_t state;

    logic                   req_we;
    dcache_pkg::word_addr_t req_addr;
    dcache_pkg::word_t      req_wdata;
    dcache_pkg::way_t       fill_way_q;

    dcache_pkg::index_t     req_index;
    dcache_pkg::line_addr_t req_line;
    logic                   l2_hs_ack;   // l2 ack seen on our own request
    logic                   l2_hs_idle;  // both l2 lines low, transaction over

    function automatic dcache_pkg::word_t pick_word(input dcache_pkg::line_t line,
                                                    input dcache_pkg::offset_t off);
        return line[off*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    endfunction

    assign req_index  = req_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign req_line   = req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
    assign l2_hs_ack  = l2_req && l2_ack;
    assign l2_hs_idle = !l2_req && !l2_ack;

    // new index goes straight to the arrays so LOOKUP sees it next cycle
    assign arr.index      = (state == dcache_pkg::IDLE && cpu_req)
                            ? cpu_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W]
                            : req_index;
    assign arr.tag        = req_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign arr.offset     = req_addr[dcache_pkg::OFFSET_W-1:0];
    assign arr.word_we    = (state == dcache_pkg::WRITE_WORD);
    assign arr.word_wdata = req_wdata;
    assign arr.set_dirty  = (state == dcache_pkg::WRITE_WORD);
    assign arr.line_we    = (state == dcache_pkg::REFILL) && l2_hs_ack;
    assign arr.line_wdata = l2_rdata;
    assign arr.fill_way   = fill_way_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= dcache_pkg::IDLE;
            cpu_ack <= 1'b0;
            l2_req  <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (cpu_req) begin
                        req_we    <= cpu_we;
                        req_addr  <= cpu_addr;
                        req_wdata <= cpu_wdata;
                        state     <= dcache_pkg::LOOKUP;
                    end
                end
                dcache_pkg::LOOKUP: begin
                    if (arr.hit) begin
                        state <= req_we ? dcache_pkg::WRITE_WORD : dcache_pkg::RESPOND;
                    end else begin
                        fill_way_q <= arr.victim_way;
                        l2_req     <= 1'b1;
                        if (arr.victim_dirty) begin
                            l2_we    <= 1'b1;  // evict first
                            l2_addr  <= {arr.victim_tag, req_index};
                            l2_wdata <= arr.victim_line;
                            state    <= dcache_pkg::WRITEBACK;
                        end else begin
                            l2_we   <= 1'b0;
                            l2_addr <= req_line;
                            state   <= dcache_pkg::REFILL;
                        end
                    end
                end
                dcache_pkg::WRITE_WORD: begin
                    state <= dcache_pkg::RESPOND;  // word and dirty bit written this edge
                end
                dcache_pkg::WRITEBACK: begin
                    if (l2_hs_ack) begin
                        l2_req <= 1'b0;
                    end else if (l2_hs_idle) begin
                        l2_req  <= 1'b1;
                        l2_we   <= 1'b0;
                        l2_addr <= req_line;
                        state   <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL: begin
                    if (l2_hs_ack) begin
                        l2_req <= 1'b0;
                        if (!req_we) begin
                            cpu_rdata <= pick_word(l2_rdata, arr.offset);
                        end
                    end else if (l2_hs_idle) begin
                        if (req_we) begin
                            state <= dcache_pkg::LOOKUP;  // retry as a write hit
                        end else begin
                            cpu_ack <= 1'b1;
                            state   <= dcache_pkg::DONE;
                        end
                    end
                end
                dcache_pkg::RESPOND: begin
                    if (!req_we) begin
                        cpu_rdata <= pick_word(arr.hit_line, arr.offset);
                    end
                    cpu_ack <= 1'b1;
                    state   <= dcache_pkg::DONE;
                end
                dcache_pkg::DONE: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= dcache_pkg::IDLE;
                    end
                end
                default: state <= dcache_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_data_array.sv */
// data array: two banks of cache lines with word and line write ports
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic        clk,
    l1_array_if.data    arr
);

    dcache_pkg::line_t bank [2][dcache_pkg::NUM_SETS];

    dcache_pkg::line_t rd_line0;
    dcache_pkg::line_t rd_line1;

    // writes land on the edge their enable is high
    always_ff @(posedge clk) begin
        if (arr.line_we) begin
            bank[arr.fill_way][arr.index] <= arr.line_wdata;
        end else if (arr.word_we) begin
            bank[arr.hit_way][arr.index][arr.offset*dcache_pkg::WORD_W +: dcache_pkg::WORD_W]
                <= arr.word_wdata;
        end
    end

    // read both ways, old data on a same-edge write
    always_ff @(posedge clk) begin
        rd_line0 <= bank[0][arr.index];
        rd_line1 <= bank[1][arr.index];
    end

    // way selection follows the tag array's compare
    assign arr.hit_line    = arr.hit_way    ? rd_line1 : rd_line0;
    assign arr.victim_line = arr.victim_way ? rd_line1 : rd_line0;

endmodule

`default_nettype wire

/* verilog/dcache_tag_array.sv */
// tag array: tags, valid, dirty and lru per set, with hit and victim selection
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input  logic        clk,
    input  logic        reset,
    l1_array_if.tags    arr
);

    dcache_pkg::tag_t                           tag_mem [2][dcache_pkg::NUM_SETS];
    logic [1:0][dcache_pkg::NUM_SETS-1:0]       valid_q;
    logic [1:0][dcache_pkg::NUM_SETS-1:0]       dirty_q;
    logic [dcache_pkg::NUM_SETS-1:0]            lru_q;   // names the next victim

    dcache_pkg::tag_t   rd_tag [2];
    logic [1:0]         rd_valid;
    logic [1:0]         rd_dirty;
    logic               rd_lru;
    dcache_pkg::index_t rd_index;  // set that the read registers belong to

    logic               hit0;
    logic               hit1;

    // synchronous read of both ways
    always_ff @(posedge clk) begin
        rd_tag[0]   <= tag_mem[0][arr.index];
        rd_tag[1]   <= tag_mem[1][arr.index];
        rd_valid[0] <= valid_q[0][arr.index];
        rd_valid[1] <= valid_q[1][arr.index];
        rd_dirty[0] <= dirty_q[0][arr.index];
        rd_dirty[1] <= dirty_q[1][arr.index];
        rd_lru      <= lru_q[arr.index];
        rd_index    <= arr.index;
    end

    assign hit0 = rd_valid[0] && (rd_tag[0] == arr.tag);
    assign hit1 = rd_valid[1] && (rd_tag[1] == arr.tag);

    assign arr.hit     = hit0 | hit1;
    assign arr.hit_way = ~hit0;  // way0 wins, don't care on a miss

    // invalid way0 first, then invalid way1, else lru
    assign arr.victim_way   = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : rd_lru);
    assign arr.victim_dirty = rd_valid[arr.victim_way] && rd_dirty[arr.victim_way];
    assign arr.victim_tag   = rd_tag[arr.victim_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (arr.line_we) begin
                valid_q[arr.fill_way][arr.index] <= 1'b1;
                lru_q[arr.index]                 <= ~arr.fill_way;
            end else if (arr.hit) begin
                // repeated touches of the same way leave lru unchanged
                lru_q[rd_index] <= ~arr.hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.line_we) begin
            tag_mem[arr.fill_way][arr.index] <= arr.tag;
            dirty_q[arr.fill_way][arr.index] <= 1'b0;  // fresh line from l2
        end
        if (arr.set_dirty) begin
            dirty_q[arr.hit_way][arr.index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/l1_array_if.sv */
// array bundle between the cache controller and its tag and data storage
`timescale 1ns/1ps
`default_nettype none

interface l1_array_if;

    // request side, from the controller
    dcache_pkg::index_t  index;
    dcache_pkg::tag_t    tag;
    dcache_pkg::offset_t offset;
    logic                word_we;
    dcache_pkg::word_t   word_wdata;
    logic                line_we;
    dcache_pkg::line_t   line_wdata;
    dcache_pkg::way_t    fill_way;
    logic                set_dirty;

    // lookup results, one cycle after index
    logic                hit;
    dcache_pkg::way_t    hit_way;
    dcache_pkg::way_t    victim_way;
    logic                victim_dirty;
    dcache_pkg::tag_t    victim_tag;
    dcache_pkg::line_t   hit_line;
    dcache_pkg::line_t   victim_line;

    modport ctrl (
        output index, tag, offset, word_we, word_wdata, line_we, line_wdata, fill_way,
               set_dirty,
        input  hit, victim_way, victim_dirty, victim_tag, hit_line, victim_line
    );

    modport tags (
        input  index, tag, line_we, fill_way, set_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  index, offset, word_we, word_wdata, line_we, line_wdata, fill_way, hit_way,
               victim_way,
        output hit_line, victim_line
    );

endinterface

`default_nettype wire

/* verilog/dcache_pkg.sv */
// dcache geometry, shared vector types and the controller state encoding
`default_nettype none

package dcache_pkg;

    localparam int WORD_W         = 32;
    localparam int ADDR_W         = 30;  // word address, byte bits already dropped
    localparam int OFFSET_W       = 2;
    localparam int INDEX_W        = 8;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int LINE_ADDR_W    = TAG_W + INDEX_W;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [ADDR_W-1:0]      word_addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;  // {tag, index}
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [OFFSET_W-1:0]    offset_t;
    typedef logic [LINE_W-1:0]      line_t;       // word 0 in the low bits
    typedef logic                   way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_WORD,
        WRITEBACK,
        REFILL,
        RESPOND,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire
